//--- files.f
+incdir+test
verilog/div_pkg.sv
verilog/div_decode.sv
verilog/div_iterate.sv
verilog/div_result.sv
verilog/div_unit.sv
test/div_tb.sv

//--- Makefile
# Verilator build and run of the divider testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_LINE ?= TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/div_model.svh
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// ==================================================
// reference model, RISC-V M-extension rules
// ==================================================

function automatic logic [63:0] sext_word(input logic [31:0] w);
  return {{32{w[31]}}, w};
endfunction

function automatic logic [63:0] model_full(input bit sgn, input bit rem,
                                           input logic [63:0] a, input logic [63:0] b);
  longint sa;
  longint sb;
  sa = $signed(a);
  sb = $signed(b);
  if (b == 64'd0) return rem ? a : '1;               // divide by zero
  if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) return rem ? 64'd0 : a; // overflow
  if (sgn) return rem ? 64'(sa % sb) : 64'(sa / sb);  // truncates toward zero
  return rem ? a % b : a / b;
endfunction

function automatic logic [63:0] model_word(input bit sgn, input bit rem,
                                           input logic [31:0] a, input logic [31:0] b);
  int sa;
  int sb;
  sa = $signed(a);
  sb = $signed(b);
  if (b == 32'd0) return rem ? sext_word(a) : '1;
  if (sgn && a == 32'h8000_0000 && b == '1) return rem ? 64'd0 : sext_word(a);
  if (sgn) return rem ? sext_word(32'(sa % sb)) : sext_word(32'(sa / sb));
  return rem ? sext_word(a % b) : sext_word(a / b);
endfunction

function automatic logic [63:0] model_result(input logic [7:0] op,
                                             input logic [63:0] a, input logic [63:0] b);
  case (op)
    div_pkg::OP_DIV:   return model_full(1'b1, 1'b0, a, b);
    div_pkg::OP_DIVU:  return model_full(1'b0, 1'b0, a, b);
    div_pkg::OP_DIVUW: return model_word(1'b0, 1'b0, a[31:0], b[31:0]);
    div_pkg::OP_DIVW:  return model_word(1'b1, 1'b0, a[31:0], b[31:0]);
    div_pkg::OP_REM:   return model_full(1'b1, 1'b1, a, b);
    div_pkg::OP_REMU:  return model_full(1'b0, 1'b1, a, b);
    div_pkg::OP_REMUW: return model_word(1'b0, 1'b1, a[31:0], b[31:0]);
    div_pkg::OP_REMW:  return model_word(1'b1, 1'b1, a[31:0], b[31:0]);
    default:           return 64'd0;                   // unknown code
  endcase
endfunction

// edges after the accepting edge until result_valid_o is seen
function automatic int model_latency(input logic [7:0] op,
                                     input logic [63:0] a, input logic [63:0] b);
  bit          word;
  bit          sgn;
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] min_val;
  word    = op inside {div_pkg::OP_DIVW, div_pkg::OP_DIVUW, div_pkg::OP_REMW, div_pkg::OP_REMUW};
  sgn     = op inside {div_pkg::OP_DIV, div_pkg::OP_DIVW, div_pkg::OP_REM, div_pkg::OP_REMW};
  ea      = word ? sext_word(a[31:0]) : a;
  eb      = word ? sext_word(b[31:0]) : b;
  min_val = word ? sext_word(32'h8000_0000) : 64'h8000_0000_0000_0000;
  if ($countones(op) != 1) return 0;
  if (eb == 64'd0) return 0;
  if (sgn && eb == '1 && ea == min_val) return 0;
  return word ? 33 : 65;                                // steps plus the result edge
endfunction

`endif

//--- test/div_tb.sv
module div_tb;

  localparam int          NUM_RAND     = 400;
  localparam int          NUM_DIRECTED = 24;
  localparam int          NUM_TESTS    = NUM_RAND + NUM_DIRECTED;
  localparam int          WAIT_LIMIT   = 200;
  localparam int          WATCH_CYCLES = NUM_TESTS * 70 + 500;
  localparam logic [31:0] SEED         = 32'd17;

  logic        clk;
  logic        rst_n;
  logic        div_valid_i;
  logic [7:0]  div_op_i;
  logic [63:0] dividend_i;
  logic [63:0] divisor_i;
  logic        result_ready_i;
  logic        busy_o;
  logic        result_valid_o;
  logic [63:0] result_o;

  logic [31:0] lfsr;
  int          checks;
  int          value_errors;
  int          timing_errors;

  `include "div_model.svh"

  div_unit dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  always #5 clk = ~clk;

  // ==================================================
  // random source
  // ==================================================
  // galois, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [63:0] rand_operand();
    logic [1:0]  kind;
    logic [63:0] v;
    kind = 2'(rand_bits(2));
    case (kind)
      2'd0: v = rand_bits(64);
      2'd1: begin
        v = rand_bits(4);                               // small, maybe negative
        if (rand_bits(1) != 64'd0) v = -v;
      end
      2'd2: v = sext_word(32'(rand_bits(32)));          // 32-bit significant
      default: v = {1'b1, 63'(rand_bits(63))};          // negative
    endcase
    return v;
  endfunction

  // ==================================================
  // one request, from strobe to consumption
  // ==================================================
  task automatic run_op(input string name, input logic [7:0] op, input logic [63:0] a,
                        input logic [63:0] b, input int hold, input bit inject);
    logic [63:0] exp;
    logic [63:0] held;
    int          exp_lat;
    int          lat;
    int          i;
    exp     = model_result(op, a, b);
    exp_lat = model_latency(op, a, b);
    @(negedge clk);
    assert (!busy_o) else begin
      $display("%s: unit still busy when the request was due", name);
      timing_errors++;
    end
    div_valid_i = 1'b1;
    div_op_i    = op;
    dividend_i  = a;
    divisor_i   = b;
    @(negedge clk);
    assert (busy_o) else begin
      $display("%s: request was not accepted", name);
      timing_errors++;
    end
    lat = 0;
    while (!result_valid_o && lat < WAIT_LIMIT) begin
      div_valid_i = inject && (lat == 3);               // second strobe mid-division
      if (inject && lat == 3) begin
        div_op_i   = div_pkg::OP_DIVU;
        dividend_i = rand_operand();
        divisor_i  = 64'd3;
      end
      @(negedge clk);
      lat++;
    end
    div_valid_i = 1'b0;
    assert (result_valid_o) else begin
      $display("%s: no result_valid_o within %0d cycles", name, WAIT_LIMIT);
      timing_errors++;
    end
    if (!result_valid_o) return;
    assert (lat == exp_lat) else begin
      $display("%s: result_valid_o rose %0d cycles after acceptance, %0d expected",
               name, lat, exp_lat);
      timing_errors++;
    end
    checks++;
    assert (result_o === exp) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp, result_o);
      value_errors++;
    end
    held = result_o;
    for (i = 0; i < hold; i++) begin
      div_valid_i = inject && (i == 0);                 // strobe while holding
      @(negedge clk);
      assert (result_valid_o && busy_o && result_o === held) else begin
        $display("%s: result not held while result_ready_i was low", name);
        timing_errors++;
      end
    end
    div_valid_i    = 1'b0;
    result_ready_i = 1'b1;
    @(negedge clk);
    result_ready_i = 1'b0;
    assert (!result_valid_o && !busy_o) else begin
      $display("%s: result not consumed on the first ready edge", name);
      timing_errors++;
    end
    if (inject) begin
      repeat (3) begin
        @(negedge clk);
        assert (!result_valid_o && !busy_o) else begin
          $display("%s: a request made while busy produced a result", name);
          timing_errors++;
        end
      end
    end
  endtask

  // ==================================================
  // sequence
  // ==================================================
  initial begin
    logic [7:0]  op;
    logic [63:0] a;
    logic [63:0] b;
    int          hold;
    clk            = 1'b0;
    rst_n          = 1'b1;                              // reset is active high
    div_valid_i    = 1'b0;
    div_op_i       = 8'd0;
    dividend_i     = 64'd0;
    divisor_i      = 64'd0;
    result_ready_i = 1'b0;
    lfsr           = SEED;
    checks         = 0;
    value_errors   = 0;
    timing_errors  = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b0;
    assert (!busy_o && !result_valid_o && result_o == 64'd0) else begin
      $display("outputs not cleared by reset");
      timing_errors++;
    end

    // divide by zero, word divisors keep junk in the upper half
    run_op("div_by_zero", div_pkg::OP_DIV, 64'hf123_4567_89ab_cdef, 64'd0, 0, 1'b0);
    run_op("divu_by_zero", div_pkg::OP_DIVU, 64'h1234_5678_9abc_def0, 64'd0, 1, 1'b0);
    run_op("rem_by_zero", div_pkg::OP_REM, 64'h8000_0000_0000_0005, 64'd0, 2, 1'b0);
    run_op("remu_by_zero", div_pkg::OP_REMU, 64'hdead_beef_0000_0001, 64'd0, 0, 1'b0);
    run_op("divw_by_zero", div_pkg::OP_DIVW, 64'h0000_0001_8000_0007,
           64'hffff_0000_0000_0000, 1, 1'b0);
    run_op("divuw_by_zero", div_pkg::OP_DIVUW, 64'h0000_0000_0000_0042,
           64'h0000_0001_0000_0000, 0, 1'b0);
    run_op("remw_by_zero", div_pkg::OP_REMW, 64'h1111_2222_f000_0003, 64'd0, 2, 1'b0);
    run_op("remuw_by_zero", div_pkg::OP_REMUW, 64'h0000_0000_8000_0001,
           64'h1234_0000_0000_0000, 1, 1'b0);

    // most negative divided by minus one
    run_op("div_overflow", div_pkg::OP_DIV, 64'h8000_0000_0000_0000, '1, 1, 1'b0);
    run_op("rem_overflow", div_pkg::OP_REM, 64'h8000_0000_0000_0000, '1, 0, 1'b0);
    run_op("divw_overflow", div_pkg::OP_DIVW, 64'h1111_2222_8000_0000,
           64'h0000_0003_ffff_ffff, 2, 1'b0);
    run_op("remw_overflow", div_pkg::OP_REMW, 64'h0000_0000_8000_0000, '1, 0, 1'b0);

    // codes that are not one-hot
    run_op("op_none", 8'h00, 64'd100, 64'd7, 0, 1'b0);
    run_op("op_two_low", 8'h03, 64'd100, 64'd7, 1, 1'b0);
    run_op("op_all", 8'hff, 64'd100, 64'd7, 0, 1'b0);
    run_op("op_ends", 8'h81, 64'hffff_ffff_ffff_fff0, 64'd3, 2, 1'b0);
    run_op("op_mid", 8'h18, 64'd9, 64'd0, 0, 1'b0);
    run_op("op_pair", 8'h60, 64'h8000_0000_0000_0000, '1, 1, 1'b0);

    // normal latency, both widths
    run_op("divu_small", div_pkg::OP_DIVU, 64'd100, 64'd7, 0, 1'b0);
    run_op("div_negative", div_pkg::OP_DIV, -64'd100, 64'd7, 1, 1'b0);
    run_op("divw_basic", div_pkg::OP_DIVW, 64'h0000_0000_ffff_ff9c, 64'd7, 0, 1'b0);
    run_op("remuw_basic", div_pkg::OP_REMUW, 64'habcd_0000_f000_0000, 64'd10, 1, 1'b0);

    // second strobe while busy is ignored
    run_op("busy_full", div_pkg::OP_DIV, 64'h7654_3210_fedc_ba98, -64'd13, 3, 1'b1);
    run_op("busy_word", div_pkg::OP_REMW, 64'h0000_0000_8765_4321, 64'd97, 2, 1'b1);

    for (int n = 0; n < NUM_RAND; n++) begin
      op   = 8'd1 << rand_bits(3);
      a    = rand_operand();
      b    = rand_operand();
      hold = int'(rand_bits(2));                        // ready held low 0..3 cycles
      run_op($sformatf("random_%0d_op%h", n, op), op, a, b, hold, 1'b0);
    end

    $display("summary: %0d results checked, %0d value errors, %0d timing errors",
             checks, value_errors, timing_errors);
    if (value_errors + timing_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // ==================================================
  // watchdog
  // ==================================================
  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog/div_unit.sv
module div_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     div_valid_i,
  input  logic [div_pkg::OP_W-1:0] div_op_i,
  input  logic [div_pkg::XLEN-1:0] dividend_i,
  input  logic [div_pkg::XLEN-1:0] divisor_i,
  input  logic                     result_ready_i,
  output logic                     busy_o,
  output logic                     result_valid_o,
  output logic [div_pkg::XLEN-1:0] result_o
);

  // ==================================================
  // internal nets
  // ==================================================
  logic                      start;
  logic                      finish_now;
  logic [div_pkg::XLEN-1:0]  finish_value;
  logic [div_pkg::XLEN-1:0]  mag_dividend;
  logic [div_pkg::XLEN-1:0]  mag_divisor;
  logic [div_pkg::CNT_W-1:0] iter_count;
  logic                      is_rem;
  logic                      is_word;
  logic                      q_neg;
  logic                      r_neg;
  logic                      done;
  logic [div_pkg::XLEN-1:0]  quotient;
  logic [div_pkg::XLEN-1:0]  remainder;
  logic                      busy;

  // ==================================================
  // blocks
  // ==================================================
  div_decode u_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .busy_i         (busy),
    .start_o        (start),
    .finish_now_o   (finish_now),
    .finish_value_o (finish_value),
    .mag_dividend_o (mag_dividend),
    .mag_divisor_o  (mag_divisor),
    .iter_count_o   (iter_count),
    .is_rem_o       (is_rem),
    .is_word_o      (is_word),
    .q_neg_o        (q_neg),
    .r_neg_o        (r_neg)
  );

  div_iterate u_iterate (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start),
    .mag_dividend_i (mag_dividend),
    .mag_divisor_i  (mag_divisor),
    .iter_count_i   (iter_count),
    .done_o         (done),
    .quotient_o     (quotient),
    .remainder_o    (remainder)
  );

  div_result u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start),
    .finish_now_i   (finish_now),
    .finish_value_i (finish_value),
    .is_rem_i       (is_rem),
    .is_word_i      (is_word),
    .q_neg_i        (q_neg),
    .r_neg_i        (r_neg),
    .done_i         (done),
    .quotient_i     (quotient),
    .remainder_i    (remainder),
    .result_ready_i (result_ready_i),
    .busy_o         (busy),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  assign busy_o = busy;

endmodule

//--- verilog/div_result.sv
module div_result (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_i,
  input  logic                     finish_now_i,
  input  logic [div_pkg::XLEN-1:0] finish_value_i,
  input  logic                     is_rem_i,
  input  logic                     is_word_i,
  input  logic                     q_neg_i,
  input  logic                     r_neg_i,
  input  logic                     done_i,
  input  logic [div_pkg::XLEN-1:0] quotient_i,
  input  logic [div_pkg::XLEN-1:0] remainder_i,
  input  logic                     result_ready_i,
  output logic                     busy_o,
  output logic                     result_valid_o,
  output logic [div_pkg::XLEN-1:0] result_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CALC,
    S_HOLD
  } state_t;

  state_t                   state_q;
  logic [div_pkg::XLEN-1:0] result_q;

  // flags of the division in flight
  logic                     is_rem_q;
  logic                     is_word_q;
  logic                     q_neg_q;
  logic                     r_neg_q;

  logic [div_pkg::XLEN-1:0] q_fix;
  logic [div_pkg::XLEN-1:0] r_fix;
  logic [div_pkg::XLEN-1:0] sel;
  logic [div_pkg::XLEN-1:0] final_val;

  // ==================================================
  // sign restore and word extension
  // ==================================================
  assign q_fix     = q_neg_q ? (~quotient_i + 64'd1) : quotient_i;
  assign r_fix     = r_neg_q ? (~remainder_i + 64'd1) : remainder_i;
  assign sel       = is_rem_q ? r_fix : q_fix;
  assign final_val = is_word_q ? {{32{sel[31]}}, sel[31:0]} : sel;

  always_ff @(posedge clk) begin
    if (start_i) begin
      is_rem_q  <= is_rem_i;
      is_word_q <= is_word_i;
      q_neg_q   <= q_neg_i;
      r_neg_q   <= r_neg_i;
    end
  end

  // ==================================================
  // control FSM
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q  <= S_IDLE;
      result_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (finish_now_i) begin
            result_q <= finish_value_i;             // special case, no iterations
            state_q  <= S_HOLD;
          end else if (start_i) begin
            state_q <= S_CALC;
          end
        end
        S_CALC: begin
          if (done_i) begin
            result_q <= final_val;
            state_q  <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (result_ready_i) begin
            state_q <= S_IDLE;                      // consumed on this edge
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  assign busy_o         = (state_q != S_IDLE);
  assign result_valid_o = (state_q == S_HOLD);
  assign result_o       = result_q;

endmodule

//--- verilog/div_iterate.sv
module div_iterate (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  logic [div_pkg::XLEN-1:0]  mag_dividend_i,
  input  logic [div_pkg::XLEN-1:0]  mag_divisor_i,
  input  logic [div_pkg::CNT_W-1:0] iter_count_i,
  output logic                      done_o,
  output logic [div_pkg::XLEN-1:0]  quotient_o,
  output logic [div_pkg::XLEN-1:0]  remainder_o
);

  // {partial remainder, dividend bits / quotient bits}
  logic [2*div_pkg::XLEN-1:0] acc_q;
  logic [div_pkg::XLEN-1:0]   divisor_q;
  logic [div_pkg::CNT_W-1:0]  cnt_q;
  logic                       done_q;

  logic                       running;
  logic                       last_step;
  logic [div_pkg::XLEN:0]     rem_shift;
  logic [div_pkg::XLEN+1:0]   trial;
  logic                       q_bit;
  logic [div_pkg::XLEN-1:0]   rem_next;

  // ==================================================
  // one restoring step
  // ==================================================
  assign running   = (cnt_q != '0);
  assign last_step = running & (cnt_q[div_pkg::CNT_W-1:1] == '0); // count is 1

  // the remainder gets one extra bit, since a top bit of 1 would be lost
  // on the shift once the divisor exceeds 2^63
  assign rem_shift = {acc_q[2*div_pkg::XLEN-1:div_pkg::XLEN], acc_q[div_pkg::XLEN-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, divisor_q};
  assign q_bit     = ~trial[div_pkg::XLEN+1];       // no borrow -> keep difference
  assign rem_next  = q_bit ? trial[div_pkg::XLEN-1:0] : rem_shift[div_pkg::XLEN-1:0];

  // ==================================================
  // counter and done strobe
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= last_step;                          // high the cycle after the last step
      if (start_i) begin
        cnt_q <= iter_count_i;
      end else if (running) begin
        cnt_q <= cnt_q - {{(div_pkg::CNT_W-1){1'b0}}, 1'b1};
      end
    end
  end

  // ==================================================
  // datapath registers
  // ==================================================
  always_ff @(posedge clk) begin
    if (start_i) begin
      acc_q     <= {{div_pkg::XLEN{1'b0}}, mag_dividend_i};
      divisor_q <= mag_divisor_i;
    end else if (running) begin
      acc_q <= {rem_next, acc_q[div_pkg::XLEN-2:0], q_bit}; // shift in quotient bit
    end
  end

  // Word operations start with the dividend in the upper half of the
  // low word, so after 32 steps the quotient sits in bits 31:0 and
  // the upper 32 bits of the low word are zero.
  assign done_o      = done_q;
  assign quotient_o  = acc_q[div_pkg::XLEN-1:0];
  assign remainder_o = acc_q[2*div_pkg::XLEN-1:div_pkg::XLEN];

endmodule

//--- verilog/div_decode.sv
module div_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      div_valid_i,
  input  logic [div_pkg::OP_W-1:0]  div_op_i,
  input  logic [div_pkg::XLEN-1:0]  dividend_i,
  input  logic [div_pkg::XLEN-1:0]  divisor_i,
  input  logic                      busy_i,
  output logic                      start_o,
  output logic                      finish_now_o,
  output logic [div_pkg::XLEN-1:0]  finish_value_o,
  output logic [div_pkg::XLEN-1:0]  mag_dividend_o,
  output logic [div_pkg::XLEN-1:0]  mag_divisor_o,
  output logic [div_pkg::CNT_W-1:0] iter_count_o,
  output logic                      is_rem_o,
  output logic                      is_word_o,
  output logic                      q_neg_o,
  output logic                      r_neg_o
);

  logic                     known;
  logic                     is_signed;
  logic                     is_word;
  logic                     is_rem;
  logic [div_pkg::XLEN-1:0] a_ext;
  logic [div_pkg::XLEN-1:0] b_ext;
  logic [div_pkg::XLEN-1:0] a_abs;
  logic [div_pkg::XLEN-1:0] b_abs;
  logic [div_pkg::XLEN-1:0] min_val;
  logic                     a_neg;
  logic                     b_neg;
  logic                     div_zero;
  logic                     overflow;
  logic                     special;
  logic                     req;

  // ==================================================
  // op classification
  // ==================================================
  always_comb begin
    known     = 1'b1;
    is_signed = 1'b0;
    is_word   = 1'b0;
    is_rem    = 1'b0;
    case (div_op_i)
      div_pkg::OP_DIV: begin
        is_signed = 1'b1;
      end
      div_pkg::OP_DIVU: begin
        is_signed = 1'b0;
      end
      div_pkg::OP_DIVUW: begin
        is_word = 1'b1;
      end
      div_pkg::OP_DIVW: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
      end
      div_pkg::OP_REM: begin
        is_signed = 1'b1;
        is_rem    = 1'b1;
      end
      div_pkg::OP_REMU: begin
        is_rem = 1'b1;
      end
      div_pkg::OP_REMUW: begin
        is_word = 1'b1;
        is_rem  = 1'b1;
      end
      div_pkg::OP_REMW: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
        is_rem    = 1'b1;
      end
      default: begin
        known = 1'b0;                               // not one of the eight
      end
    endcase
  end

  // ==================================================
  // operands and special cases
  // ==================================================
  assign a_ext = is_word ? {{32{dividend_i[31]}}, dividend_i[31:0]} : dividend_i;
  assign b_ext = is_word ? {{32{divisor_i[31]}}, divisor_i[31:0]} : divisor_i;

  assign a_neg = is_signed & a_ext[div_pkg::XLEN-1];
  assign b_neg = is_signed & b_ext[div_pkg::XLEN-1];
  assign a_abs = a_neg ? (~a_ext + 64'd1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 64'd1) : b_ext;

  assign min_val  = is_word ? {{33{1'b1}}, 31'b0} : {1'b1, 63'b0}; // most negative
  assign div_zero = (b_ext == '0);                  // sext keeps zero test valid
  assign overflow = is_signed & (a_ext == min_val) & (&b_ext);
  assign special  = ~known | div_zero | overflow;

  // fixed result, already sign-extended for word ops
  always_comb begin
    if (!known) begin
      finish_value_o = '0;
    end else if (div_zero) begin
      finish_value_o = is_rem ? a_ext : '1;
    end else if (overflow) begin
      finish_value_o = is_rem ? '0 : a_ext;
    end else begin
      finish_value_o = '0;
    end
  end

  // ==================================================
  // request steering
  // ==================================================
  assign req          = div_valid_i & ~busy_i & ~rst_n; // nothing taken in reset
  assign start_o      = req & ~special;
  assign finish_now_o = req & special;

  // word dividend goes high so 32 shifts bring it all in
  assign mag_dividend_o = is_word ? {a_abs[31:0], 32'b0} : a_abs;
  assign mag_divisor_o  = is_word ? {32'b0, b_abs[31:0]} : b_abs;
  assign iter_count_o   = is_word ? div_pkg::ITER_W : div_pkg::ITER_D;

  assign is_rem_o  = is_rem;
  assign is_word_o = is_word;
  assign q_neg_o   = a_neg ^ b_neg;
  assign r_neg_o   = a_neg;                         // remainder follows dividend

endmodule

//--- verilog/div_pkg.sv
package div_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int XLEN  = 64;                        // rv64 register width
  localparam int OP_W  = 8;                         // one-hot op code width
  localparam int CNT_W = 7;                         // holds up to 64 steps

  // ==================================================
  // iteration counts
  // ==================================================
  localparam logic [CNT_W-1:0] ITER_D = 7'd64;      // full-width ops
  localparam logic [CNT_W-1:0] ITER_W = 7'd32;      // word ops, dividend pre-shifted

  // ==================================================
  // one-hot operation codes
  // ==================================================
  // quotient, signed, 64 bit
  localparam logic [OP_W-1:0] OP_DIV   = 8'b1000_0000;

  // quotient, unsigned, 64 bit
  localparam logic [OP_W-1:0] OP_DIVU  = 8'b0100_0000;

  // quotient, unsigned, low 32 bits, result sign-extended
  localparam logic [OP_W-1:0] OP_DIVUW = 8'b0010_0000;

  // quotient, signed, low 32 bits, result sign-extended
  localparam logic [OP_W-1:0] OP_DIVW  = 8'b0001_0000;

  // remainder, signed, 64 bit
  localparam logic [OP_W-1:0] OP_REM   = 8'b0000_1000;

  // remainder, unsigned, 64 bit
  localparam logic [OP_W-1:0] OP_REMU  = 8'b0000_0100;

  // remainder, unsigned, low 32 bits, result sign-extended
  localparam logic [OP_W-1:0] OP_REMUW = 8'b0000_0010;

  // remainder, signed, low 32 bits, result sign-extended
  localparam logic [OP_W-1:0] OP_REMW  = 8'b0000_0001;

  // Sign of the remainder always follows the dividend, and the
  // quotient is negative when exactly one operand is negative.
  // Division by zero gives an all-ones quotient and returns the
  // dividend as remainder; the signed overflow case returns the
  // dividend as quotient and a zero remainder.

endpackage
